//--- Makefile
VERILATOR ?= verilator
TOP       ?= sparcCoreTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- flist.f
src/sparcCorePkg.sv
src/instrDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/branchCond.sv
src/pcSequencer.sv
src/sparcCore.sv
sim/sparcCoreTb.sv

//--- sim/sparcCoreTb.sv
`timescale 1ns/1ps

module sparcCoreTb import sparcCorePkg::*; ();

    localparam word_t ResetPc   = 32'h0000_0040;
    localparam int    MemWords  = 1024;
    localparam int    StepLimit = 2000;

    // SPARC op3 codes used to build programs
    localparam logic [5:0] op3Add  = 6'h00;
    localparam logic [5:0] op3Or   = 6'h02;
    localparam logic [5:0] op3Sub  = 6'h04;
    localparam logic [5:0] op3Addx = 6'h08;
    localparam logic [5:0] op3Subx = 6'h0C;
    localparam logic [5:0] ccBit   = 6'h10;

    localparam longint MaxInt  = 64'sd2147483647;
    localparam longint MinInt  = -64'sd2147483648;
    localparam longint MaxUint = 64'sd4294967295;

    logic     Clk;
    logic     rst;
    word_t    instr;
    word_t    pc;
    logic     wbEn;
    regAddr_t wbReg;
    word_t    wbData;
    ccFlags_t icc;

    word_t    imem [0:MemWords-1];  // Instruction memory, word per pc/4
    int       wrPtr;
    int       errors;
    int       checks;
    int       timeouts;
    integer   seed;

    // Reference model state
    word_t    refRegs [0:31];
    ccFlags_t refIcc;
    word_t    refPc;
    word_t    refNpc;
    logic     refAnnul;

    always #10 Clk = ~Clk;

    sparcCore #(
        .ResetPc (ResetPc)
    ) dut (
        .Clk    (Clk),
        .rst    (rst),
        .instr  (instr),
        .pc     (pc),
        .wbEn   (wbEn),
        .wbReg  (wbReg),
        .wbData (wbData),
        .icc    (icc)
    );

    // A reset held across an edge pins pc and clears icc
    resetPcCheck: assert property (@(negedge Clk) (rst && $past(rst)) |-> (pc == ResetPc))
    else
    begin
        $display("ERR %0t pc: got %h expected %h", $time, pc, ResetPc);
        errors++;
    end

    resetIccCheck: assert property (@(negedge Clk) (rst && $past(rst)) |-> (icc == 4'b0))
    else
    begin
        $display("ERR %0t icc: got %h expected %h", $time, icc, 4'b0);
        errors++;
    end

    function automatic word_t arithReg(logic [5:0] op3, regAddr_t rd, regAddr_t rs1,
                                       regAddr_t rs2);
        return {2'b10, rd, op3, rs1, 1'b0, 8'b0, rs2};
    endfunction

    function automatic word_t arithImm(logic [5:0] op3, regAddr_t rd, regAddr_t rs1,
                                       logic [12:0] simm);
        return {2'b10, rd, op3, rs1, 1'b1, simm};
    endfunction

    function automatic word_t sethiWord(regAddr_t rd, logic [21:0] imm22);
        return {2'b00, rd, 3'b100, imm22};
    endfunction

    function automatic word_t branchWord(logic annul, logic [3:0] cond, logic [21:0] disp);
        return {2'b00, annul, cond, 3'b010, disp};
    endfunction

    function automatic word_t callWord(logic [29:0] disp);
        return {2'b01, disp};
    endfunction

    function automatic logic [5:0] op3ForIndex(int idx);
        logic [5:0] op3;
        case (idx)
            0:       op3 = 6'h00;  // add
            1:       op3 = 6'h08;  // addx
            2:       op3 = 6'h04;  // sub
            3:       op3 = 6'h0C;  // subx
            4:       op3 = 6'h01;  // and
            5:       op3 = 6'h05;  // andn
            6:       op3 = 6'h02;  // or
            7:       op3 = 6'h06;  // orn
            8:       op3 = 6'h03;  // xor
            9:       op3 = 6'h07;  // xnor
            10:      op3 = 6'h25;  // sll
            11:      op3 = 6'h26;  // srl
            default: op3 = 6'h27;  // sra
        endcase
        return op3;
    endfunction

    // Bicc conditions as listed in the architecture manual
    function automatic logic condHolds(logic [3:0] cond, ccFlags_t f);
        logic holds;
        case (cond)
            4'd0:    holds = 1'b0;
            4'd1:    holds = f.z;
            4'd2:    holds = f.z || (f.n != f.v);
            4'd3:    holds = (f.n != f.v);
            4'd4:    holds = f.c || f.z;
            4'd5:    holds = f.c;
            4'd6:    holds = f.n;
            4'd7:    holds = f.v;
            4'd8:    holds = 1'b1;
            4'd9:    holds = !f.z;
            4'd10:   holds = !(f.z || (f.n != f.v));
            4'd11:   holds = (f.n == f.v);
            4'd12:   holds = !f.c && !f.z;
            4'd13:   holds = !f.c;
            4'd14:   holds = !f.n;
            default: holds = !f.v;
        endcase
        return holds;
    endfunction

    // Overflow and carry judged on wide integer ranges
    task automatic refArith(input logic [5:0] op3, input word_t a, input word_t b,
                            input logic cin, output word_t res, output ccFlags_t fl,
                            output logic valid);
        longint ua;
        longint ub;
        longint sa;
        longint sb;
        longint ci;
        longint us;
        longint ss;
        ua = longint'(a);
        ub = longint'(b);
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ci = ((op3[3:0] == 4'h8) || (op3[3:0] == 4'hC)) ? longint'(cin) : 0;
        valid = 1'b1;
        res = '0;
        fl = '0;
        case (op3)
            6'h25: res = a << b[4:0];
            6'h26: res = a >> b[4:0];
            6'h27: res = (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
            default:
            begin
                if (op3[5])
                begin
                    valid = 1'b0;
                end
                case (op3[3:0])
                    4'h0, 4'h8:
                    begin
                        us = ua + ub + ci;
                        ss = sa + sb + ci;
                        res = us[31:0];
                        fl.c = (us > MaxUint);
                        fl.v = (ss > MaxInt) || (ss < MinInt);
                    end
                    4'h4, 4'hC:
                    begin
                        us = ua - ub - ci;
                        ss = sa - sb - ci;
                        res = us[31:0];
                        fl.c = (us < 0);  // Borrow
                        fl.v = (ss > MaxInt) || (ss < MinInt);
                    end
                    4'h1: res = a & b;
                    4'h5: res = a & ~b;
                    4'h2: res = a | b;
                    4'h6: res = a | ~b;
                    4'h3: res = a ^ b;
                    4'h7: res = ~(a ^ b);
                    default: valid = 1'b0;
                endcase
            end
        endcase
        fl.n = res[31];
        fl.z = (res == 32'h0);
    endtask

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        checks++;
        valueMatch: assert (actual === expected)
        else
        begin
            $display("ERR %0t %s: got %h expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // Compare the current cycle, then advance the model past the next edge
    task automatic checkCycle();
        word_t    ins;
        word_t    opB;
        word_t    expData;
        word_t    target;
        regAddr_t expReg;
        ccFlags_t newFlags;
        logic     expEn;
        logic     ccWrite;
        logic     transfer;
        logic     annulNext;
        logic     valid;
        ins = imem[refPc[11:2]];
        expEn = 1'b0;
        expReg = '0;
        expData = '0;
        ccWrite = 1'b0;
        newFlags = refIcc;
        transfer = 1'b0;
        target = '0;
        annulNext = 1'b0;
        checkValue("pc", pc, refPc);
        checkValue("icc", {28'b0, icc}, {28'b0, refIcc});
        if (!refAnnul && (ins != 32'h0))
        begin
            case (ins[31:30])
                2'b01:
                begin
                    expEn = 1'b1;
                    expReg = 5'd15;
                    expData = refPc;
                    transfer = 1'b1;
                    target = refPc + {ins[29:0], 2'b00};
                end
                2'b00:
                begin
                    if (ins[24:22] == 3'b100)
                    begin
                        expEn = 1'b1;
                        expReg = ins[29:25];
                        expData = {ins[21:0], 10'b0};
                    end
                    else if (ins[24:22] == 3'b010)
                    begin
                        transfer = condHolds(ins[28:25], refIcc);
                        target = refPc + {{8{ins[21]}}, ins[21:0], 2'b00};
                        annulNext = ins[29];
                    end
                end
                2'b10:
                begin
                    opB = ins[13] ? {{19{ins[12]}}, ins[12:0]} : refRegs[ins[4:0]];
                    refArith(ins[24:19], refRegs[ins[18:14]], opB, refIcc.c, expData,
                             newFlags, valid);
                    expEn = valid;
                    expReg = ins[29:25];
                    ccWrite = valid && ins[23];
                end
                default: expEn = 1'b0;  // Memory ops are not executed
            endcase
        end
        checkValue("wbEn", {31'b0, wbEn}, {31'b0, expEn});
        if (expEn)
        begin
            checkValue("wbReg", {27'b0, wbReg}, {27'b0, expReg});
            checkValue("wbData", wbData, expData);
        end
        if (expEn && (expReg != 5'd0))
        begin
            refRegs[expReg] = expData;
        end
        if (ccWrite)
        begin
            refIcc = newFlags;
        end
        refPc = refNpc;
        refNpc = transfer ? target : refNpc + 32'd4;
        refAnnul = annulNext;
    endtask

    task automatic emit(input word_t w);
        imem[wrPtr] = w;
        wrPtr++;
    endtask

    task automatic loadConst(input regAddr_t rd, input word_t value);
        emit(sethiWord(rd, value[31:10]));
        emit(arithImm(op3Or, rd, rd, {3'b0, value[9:0]}));
    endtask

    task automatic clearProgram();
        for (int i = 0; i < MemWords; i++)
        begin
            imem[i] = '0;
        end
        wrPtr = int'(ResetPc >> 2);
        emit(32'h0);  // Program opens with a nop
    endtask

    task automatic buildAluProgram();
        word_t      rnd;
        logic [5:0] op3;
        int         idx;
        clearProgram();
        for (int r = 1; r < 16; r++)
        begin
            loadConst(regAddr_t'(r), $random(seed));
        end
        emit(arithImm(op3Sub | ccBit, 5'd0, 5'd0, 13'd1));  // Borrow sets C
        emit(arithReg(op3Addx, 5'd16, 5'd1, 5'd2));
        emit(arithImm(op3Subx | ccBit, 5'd17, 5'd3, 13'h1FFF));
        for (int i = 0; i < 60; i++)
        begin
            idx = int'({$random(seed)} % 13);
            rnd = $random(seed);
            op3 = op3ForIndex(idx);
            if (!op3[5] && rnd[13])
            begin
                op3 = op3 | ccBit;
            end
            if (rnd[12])
            begin
                emit(arithImm(op3, {1'b0, rnd[3:0]}, {1'b0, rnd[7:4]}, rnd[31:19]));
            end
            else
            begin
                emit(arithReg(op3, {1'b0, rnd[3:0]}, {1'b0, rnd[7:4]}, {1'b0, rnd[11:8]}));
            end
        end
        emit(arithImm(op3Or, 5'd0, 5'd1, 13'd5));     // Write to r0
        emit(arithReg(op3Add, 5'd18, 5'd0, 5'd0));    // r0 reads as zero
    endtask

    function automatic word_t presetWord(int p);
        word_t w;
        case (p)
            0:       w = arithImm(op3Sub | ccBit, 5'd0, 5'd0, 13'd0);   // Z
            1:       w = arithImm(op3Sub | ccBit, 5'd0, 5'd0, 13'd1);   // N C
            2:       w = arithImm(op3Add | ccBit, 5'd0, 5'd20, 13'd1);  // N V
            3:       w = arithImm(op3Add | ccBit, 5'd0, 5'd21, 13'd1);  // Z C
            4:       w = arithImm(op3Sub | ccBit, 5'd0, 5'd19, 13'd1);  // V
            default: w = arithImm(op3Add | ccBit, 5'd0, 5'd0, 13'd1);   // none
        endcase
        return w;
    endfunction

    task automatic buildBranchProgram();
        clearProgram();
        loadConst(5'd19, 32'h8000_0000);
        loadConst(5'd20, 32'h7FFF_FFFF);
        loadConst(5'd21, 32'hFFFF_FFFF);
        for (int r = 22; r < 25; r++)
        begin
            emit(arithReg(op3Or, regAddr_t'(r), 5'd0, 5'd0));
        end
        for (int p = 0; p < 6; p++)
        begin
            for (int c = 0; c < 16; c++)
            begin
                emit(presetWord(p));
                emit(branchWord(1'((p + c) & 1), 4'(c), 22'd3));
                emit(arithImm(op3Add | ccBit, 5'd22, 5'd22, 13'd1));  // Delay slot
                emit(arithImm(op3Add, 5'd23, 5'd23, 13'd1));          // Skipped when taken
                emit(arithImm(op3Add, 5'd24, 5'd24, 13'd1));          // Branch target
            end
        end
    endtask

    task automatic buildCallProgram();
        clearProgram();
        emit(sethiWord(5'd1, 22'h2A5A5));
        emit(sethiWord(5'd2, 22'h3FFFFF));
        emit(callWord(30'd4));
        emit(arithImm(op3Add, 5'd3, 5'd15, 13'd0));  // Delay slot sees the link
        emit(sethiWord(5'd4, 22'h1234));
        emit(sethiWord(5'd4, 22'h5678));
        emit(arithImm(op3Or, 5'd5, 5'd15, 13'd0));   // Call target
    endtask

    task automatic runProgram(input string name);
        word_t haltPc;
        int    steps;
        haltPc = word_t'(wrPtr * 4);
        rst = 1'b1;
        instr = '0;
        repeat (4) @(posedge Clk);
        #1;
        rst = 1'b0;
        refPc = ResetPc;
        refNpc = ResetPc + 32'd4;
        refAnnul = 1'b0;
        refIcc = '0;
        instr = imem[pc[11:2]];
        steps = 0;
        while ((pc !== haltPc) && (steps < StepLimit))
        begin
            @(negedge Clk);
            checkCycle();
            @(posedge Clk);
            #1;
            instr = imem[pc[11:2]];
            steps++;
        end
        if (pc !== haltPc)
        begin
            $display("Timeout: program %s never reached its end address %h", name, haltPc);
            timeouts++;
        end
    endtask

    initial
    begin
        Clk = 1'b0;
        rst = 1'b1;
        instr = '0;
        seed = 32'heba7bd6e;
        errors = 0;
        checks = 0;
        timeouts = 0;
        for (int r = 0; r < 32; r++)
        begin
            refRegs[r] = '0;
        end
        buildAluProgram();
        runProgram("alu");
        if (timeouts == 0)
        begin
            buildBranchProgram();
            runProgram("branch");
        end
        if (timeouts == 0)
        begin
            buildCallProgram();
            runProgram("call");
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0))
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import sparcCorePkg::*; (
    input  ctrl_t    ctrl,
    input  word_t    instr,
    input  word_t    rs1Data,
    input  word_t    rs2Data,
    input  logic     carryIn,   // icc.c
    output word_t    result,
    output ccFlags_t flags
);

    word_t       simm13;
    word_t       imm22;
    word_t       opB;
    logic        carryTerm;
    logic [32:0] sum;
    logic [32:0] diff;
    logic [4:0]  shamt;

    assign simm13 = {{19{instr[12]}}, instr[12:0]};
    assign imm22  = {instr[21:0], 10'b0};  // SETHI value

    assign opB = ctrl.sethi  ? imm22  :
                 ctrl.useImm ? simm13 : rs2Data;

    assign carryTerm = ((ctrl.aluOp == aluAddx) || (ctrl.aluOp == aluSubx)) ? carryIn : 1'b0;

    // Extra bit gives carry out, or borrow for subtract
    assign sum  = {1'b0, rs1Data} + {1'b0, opB} + {32'b0, carryTerm};
    assign diff = {1'b0, rs1Data} - {1'b0, opB} - {32'b0, carryTerm};

    assign shamt = opB[4:0];

    always_comb
    begin
        flags = '0;
        case (ctrl.aluOp)
            aluAdd, aluAddx:
            begin
                result  = sum[31:0];
                flags.c = sum[32];
                flags.v = (rs1Data[31] == opB[31]) && (result[31] != rs1Data[31]);
            end
            aluSub, aluSubx:
            begin
                result  = diff[31:0];
                flags.c = diff[32];  // Borrow
                flags.v = (rs1Data[31] != opB[31]) && (result[31] != rs1Data[31]);
            end
            aluAnd:  result = rs1Data & opB;
            aluAndn: result = rs1Data & ~opB;
            aluOr:   result = rs1Data | opB;
            aluOrn:  result = rs1Data | ~opB;
            aluXor:  result = rs1Data ^ opB;
            aluXnor: result = ~(rs1Data ^ opB);
            aluSll:  result = rs1Data << shamt;
            aluSrl:  result = rs1Data >> shamt;
            aluSra:  result = word_t'($signed(rs1Data) >>> shamt);
            default: result = opB;  // passB
        endcase
        flags.n = result[31];
        flags.z = (result == '0);
    end

endmodule

//--- src/branchCond.sv
`timescale 1ns/1ps

module branchCond import sparcCorePkg::*; (
    input  logic     Clk,
    input  logic     rst,
    input  ctrl_t    ctrl,
    input  ccFlags_t aluFlags,
    output ccFlags_t icc,
    output logic     taken
);

    logic condMet;
    logic baseCond;

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            icc <= '0;
        end
        else if (ctrl.modifyCC)
        begin
            icc <= aluFlags;
        end
    end

    // cond[3] selects the complement of the cond[2:0] test
    always_comb
    begin
        case (ctrl.cond[2:0])
            3'b000:  baseCond = 1'b0;                           // bn / ba
            3'b001:  baseCond = icc.z;                          // be / bne
            3'b010:  baseCond = icc.z | (icc.n ^ icc.v);        // ble / bg
            3'b011:  baseCond = icc.n ^ icc.v;                  // bl / bge
            3'b100:  baseCond = icc.c | icc.z;                  // bleu / bgu
            3'b101:  baseCond = icc.c;                          // bcs / bcc
            3'b110:  baseCond = icc.n;                          // bneg / bpos
            default: baseCond = icc.v;                          // bvs / bvc
        endcase
        condMet = baseCond ^ ctrl.cond[3];
    end

    assign taken = ctrl.isBranch & condMet;

endmodule

//--- src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import sparcCorePkg::*; (
    input  word_t instr,
    input  logic  squash,   // Annulled delay slot
    output ctrl_t ctrl
);

    localparam logic [2:0] op2Bicc = 3'b010;

    logic [1:0] op;
    logic [2:0] op2;
    logic [5:0] op3;
    logic       isNop;
    logic       supported;
    logic       shiftGroup;
    ctrl_t      decoded;

    assign op  = instr[31:30];
    assign op2 = instr[24:22];
    assign op3 = instr[24:19];

    assign isNop = (instr == '0);

    // Low op3 nibbles shared by the negated logic ops and the shifts
    assign shiftGroup = (op3[3:0] == 4'h5) || (op3[3:0] == 4'h6) || (op3[3:0] == 4'h7);

    always_comb
    begin
        decoded   = '0;
        supported = 1'b0;
        case (op)
            opCall:
            begin
                decoded.isCall   = 1'b1;
                decoded.rfEnable = 1'b1;  // r15 gets pc
                supported        = 1'b1;
            end
            opBranchSethi:
            begin
                if (op2 == op2Sethi)
                begin
                    decoded.sethi    = 1'b1;
                    decoded.aluOp    = aluPassB;
                    decoded.rfEnable = 1'b1;
                    supported        = 1'b1;
                end
                else if (op2 == op2Bicc)
                begin
                    decoded.isBranch = 1'b1;
                    decoded.annulBit = instr[29];
                    decoded.cond     = instr[28:25];
                    supported        = 1'b1;
                end
            end
            opArith:
            begin
                decoded.useImm   = instr[13];
                decoded.modifyCC = op3[4];  // cc variants
                decoded.rfEnable = 1'b1;
                supported        = 1'b1;
                case (op3[3:0])
                    4'h0: decoded.aluOp = aluAdd;
                    4'h8: decoded.aluOp = aluAddx;
                    4'h4: decoded.aluOp = aluSub;
                    4'hC: decoded.aluOp = aluSubx;
                    4'h1: decoded.aluOp = aluAnd;
                    4'h5: decoded.aluOp = op3[5] ? aluSll : aluAndn;
                    4'h2: decoded.aluOp = aluOr;
                    4'h6: decoded.aluOp = op3[5] ? aluSrl : aluOrn;
                    4'h3: decoded.aluOp = aluXor;
                    4'h7: decoded.aluOp = op3[5] ? aluSra : aluXnor;
                    default: supported = 1'b0;  // mul, div and friends
                endcase
                // Upper op3 half only holds the three plain shifts here
                if (op3[5] && (op3[4] || !shiftGroup))
                begin
                    supported = 1'b0;
                end
            end
            default:
            begin
                supported = 1'b0;  // Loads and stores
            end
        endcase
    end

    // Anything not executed leaves no trace
    assign ctrl = (squash || isNop || !supported) ? '0 : decoded;

endmodule

//--- src/pcSequencer.sv
`timescale 1ns/1ps

module pcSequencer import sparcCorePkg::*; #(
    parameter word_t ResetPc = 32'h0000_0000
) (
    input  logic  Clk,
    input  logic  rst,
    input  ctrl_t ctrl,
    input  word_t instr,
    input  logic  taken,
    output word_t pc,
    output logic  squash
);

    word_t npc;
    word_t disp;
    word_t target;
    logic  annul;

    // Word displacement scaled to bytes
    assign disp = ctrl.isCall ? {instr[29:0], 2'b00}
                              : {{8{instr[21]}}, instr[21:0], 2'b00};

    assign target = pc + disp;

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            pc    <= ResetPc;
            npc   <= ResetPc + 32'd4;
            annul <= 1'b0;
        end
        else
        begin
            pc <= npc;  // Delay slot comes next
            if (ctrl.isCall || taken)
            begin
                npc <= target;
            end
            else
            begin
                npc <= npc + 32'd4;
            end
            annul <= ctrl.isBranch & ctrl.annulBit;  // Taken or not
        end
    end

    assign squash = annul;

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile import sparcCorePkg::*; (
    input  logic     Clk,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    output word_t    rs1Data,
    output word_t    rs2Data,
    input  logic     wrEn,
    input  regAddr_t wrReg,
    input  word_t    wrData
);

    word_t regs [1:31];  // r0 has no storage

    always_ff @(posedge Clk)
    begin
        if (wrEn && (wrReg != '0))
        begin
            regs[wrReg] <= wrData;
        end
    end

    // Combinational reads, r0 reads as zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/sparcCore.sv
`timescale 1ns/1ps

module sparcCore import sparcCorePkg::*; #(
    parameter word_t ResetPc = 32'h0000_0000
) (
    input  logic     Clk,
    input  logic     rst,
    input  word_t    instr,   // Instruction at pc
    output word_t    pc,
    output logic     wbEn,
    output regAddr_t wbReg,
    output word_t    wbData,
    output ccFlags_t icc
);

    ctrl_t    ctrl;
    logic     squash;
    logic     taken;
    word_t    rs1Data;
    word_t    rs2Data;
    word_t    aluResult;
    ccFlags_t aluFlags;

    instrDecoder decoder (
        .instr  (instr),
        .squash (squash),
        .ctrl   (ctrl)
    );

    regFile regs (
        .Clk     (Clk),
        .rs1     (instr[18:14]),
        .rs2     (instr[4:0]),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wrEn    (wbEn),
        .wrReg   (wbReg),
        .wrData  (wbData)
    );

    aluUnit alu (
        .ctrl    (ctrl),
        .instr   (instr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .carryIn (icc.c),    // For addx and subx
        .result  (aluResult),
        .flags   (aluFlags)
    );

    branchCond branch (
        .Clk      (Clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .aluFlags (aluFlags),
        .icc      (icc),
        .taken    (taken)
    );

    pcSequencer #(
        .ResetPc (ResetPc)
    ) sequencer (
        .Clk    (Clk),
        .rst    (rst),
        .ctrl   (ctrl),
        .instr  (instr),
        .taken  (taken),
        .pc     (pc),
        .squash (squash)
    );

    // Write-back select; CALL saves its own address in r15
    assign wbEn   = ctrl.rfEnable;
    assign wbReg  = ctrl.isCall ? LinkReg : instr[29:25];
    assign wbData = ctrl.isCall ? pc : aluResult;

endmodule

//--- src/sparcCorePkg.sv
package sparcCorePkg;

    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  regAddr_t;  // Register index

    // ALU operations; passB carries the SETHI operand straight through
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluAddx  = 4'd1,
        aluSub   = 4'd2,
        aluSubx  = 4'd3,
        aluAnd   = 4'd4,
        aluAndn  = 4'd5,
        aluOr    = 4'd6,
        aluOrn   = 4'd7,
        aluXor   = 4'd8,
        aluXnor  = 4'd9,
        aluSll   = 4'd10,
        aluSrl   = 4'd11,
        aluSra   = 4'd12,
        aluPassB = 4'd13
    } aluOp_t;

    // Integer condition codes, same bit order as the PSR icc field
    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } ccFlags_t;

    // Decoded control for the instruction at pc
    typedef struct packed {
        aluOp_t      aluOp;
        logic        useImm;    // simm13 as second operand
        logic        modifyCC;  // Load icc from ALU flags
        logic        rfEnable;  // Register file write
        logic        isCall;
        logic        isBranch;
        logic        annulBit;  // Squash the delay slot
        logic [3:0]  cond;      // Bicc condition field
        logic        sethi;
    } ctrl_t;

    localparam regAddr_t LinkReg = 5'd15;  // CALL return address register

    // Instruction bits 31:30
    localparam logic [1:0] opBranchSethi = 2'b00;
    localparam logic [1:0] opCall        = 2'b01;
    localparam logic [1:0] opArith       = 2'b10;

    // Instruction bits 24:22 when op is 00
    localparam logic [2:0] op2Sethi = 3'b100;

endpackage
